// File: dv/bp_properties.sv
`timescale 1ns/1ps

module bp_properties import bp_pkg::*; (
    input logic            clk,
    input logic            rst,
    input logic            hold_i,
    input logic            btb_hit_i,
    input logic            pred_valid_i,
    input logic            pred_taken_i,
    input logic [PC_W-1:0] pred_target_i,
    input pred_info_t      pred_info_i
);

    // output register cleared by the synchronous reset
    valid_low_after_reset: assert property (
        @(posedge clk) rst |=> !pred_valid_i
    ) else $error("pred_valid_o high in the cycle after reset");

    // hold freezes the whole output register
    outputs_stable_on_hold: assert property (
        @(posedge clk) (hold_i && !rst) |=>
            ($stable(pred_valid_i) && $stable(pred_taken_i) &&
             $stable(pred_target_i) && $stable(pred_info_i))
    ) else $error("prediction outputs changed while hold_i was high");

    // a registered btb miss gives a zero target
    target_zero_on_miss: assert property (
        @(posedge clk) (!rst && !hold_i && !btb_hit_i) |=> (pred_target_i == '0)
    ) else $error("pred_target_o nonzero after a btb miss");

endmodule

bind bp_top bp_properties props0 (
    .clk           (clk),
    .rst           (rst),
    .hold_i        (hold_i),
    .btb_hit_i     (btb_hit),
    .pred_valid_i  (pred_valid_o),
    .pred_taken_i  (pred_taken_o),
    .pred_target_i (pred_target_o),
    .pred_info_i   (pred_info_o)
);

// File: dv/bp_tb.sv
`timescale 1ns/1ps

module bp_tb import bp_pkg::*; ();

    // row kinds of the stimulus table
    typedef enum logic [2:0] {
        op_predict,
        op_commit,
        op_hold,
        op_recover,
        op_pause
    } op_e;

    // pause rows keep the pc fetched while paused in the target column
    typedef struct packed {
        op_e             op;
        logic [PC_W-1:0] pc;
        logic            taken;
        logic [PC_W-1:0] target;
        logic            exp_taken;
        logic [PC_W-1:0] exp_target;
    } row_t;

    logic            clk;
    logic            rst;
    logic            pause_i;
    logic            hold_i;
    logic            recover_i;
    logic            fetch_valid_i;
    logic [PC_W-1:0] br_pc_i;
    logic            if3_is_br_i;
    logic            if3_is_j_i;
    logic            commit_valid_i;
    pred_info_t      commit_info_i;
    logic            commit_taken_i;
    logic            commit_mispred_i;
    logic            commit_target_en_i;
    logic [PC_W-1:0] commit_target_i;
    logic            pred_valid_o;
    logic            pred_taken_o;
    logic [PC_W-1:0] pred_target_o;
    pred_info_t      pred_info_o;

    row_t rows [$];
    // info and direction of the latest prediction of each pc
    pred_info_t info_by_pc [logic [PC_W-1:0]];
    logic       pred_by_pc [logic [PC_W-1:0]];

    // expected outputs of the latest checked prediction
    logic            last_exp_taken;
    logic [PC_W-1:0] last_exp_target;

    // history state tracked from the commit rows
    logic [LHIST_W-1:0] lhist_model [BHT_ENTRIES];
    logic [GHIST_W-1:0] commit_hist_model;
    logic [GHIST_W-1:0] spec_hist_model;

    int seed;
    int check_count;
    int error_count;
    int cycle_count;
    int cycle_limit;

    bp_top dut0 (
        .clk                (clk),
        .rst                (rst),
        .pause_i            (pause_i),
        .hold_i             (hold_i),
        .recover_i          (recover_i),
        .fetch_valid_i      (fetch_valid_i),
        .br_pc_i            (br_pc_i),
        .if3_is_br_i        (if3_is_br_i),
        .if3_is_j_i         (if3_is_j_i),
        .commit_valid_i     (commit_valid_i),
        .commit_info_i      (commit_info_i),
        .commit_taken_i     (commit_taken_i),
        .commit_mispred_i   (commit_mispred_i),
        .commit_target_en_i (commit_target_en_i),
        .commit_target_i    (commit_target_i),
        .pred_valid_o       (pred_valid_o),
        .pred_taken_o       (pred_taken_o),
        .pred_target_o      (pred_target_o),
        .pred_info_o        (pred_info_o)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    // run limit, set from the table length
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check_taken(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_target(input string name, input logic [PC_W-1:0] got,
                                input logic [PC_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    // index fields only, the direction bits are checked through pred_taken_o
    task automatic check_info_index(input pred_info_t got, input pred_info_t exp);
        check_count++;
        if (got.bht_idx !== exp.bht_idx || got.lpht_idx !== exp.lpht_idx ||
            got.gpht_idx !== exp.gpht_idx || got.btb_idx !== exp.btb_idx ||
            got.chooser_idx !== exp.chooser_idx) begin
            error_count++;
            $display("Fail pred_info_o.bht_idx: got %h expected %h", got.bht_idx, exp.bht_idx);
            $display("Fail pred_info_o.lpht_idx: got %h expected %h", got.lpht_idx, exp.lpht_idx);
            $display("Fail pred_info_o.gpht_idx: got %h expected %h", got.gpht_idx, exp.gpht_idx);
            $display("Fail pred_info_o.btb_idx: got %h expected %h", got.btb_idx, exp.btb_idx);
            $display("Fail pred_info_o.chooser_idx: got %h expected %h",
                     got.chooser_idx, exp.chooser_idx);
        end
    endtask

    // indices from the pc bit fields and the tracked histories
    function automatic pred_info_t expected_info(input logic [PC_W-1:0] pc);
        pred_info_t e;
        bht_index_t b;
        e             = '0;
        b             = pc[PC_LSB +: BHT_BITS];
        e.bht_idx     = b;
        e.lpht_idx    = lhist_model[b] ^ pc[PC_LSB +: LHIST_W];
        e.gpht_idx    = spec_hist_model ^ pc[PC_LSB +: GHIST_W];
        e.btb_idx     = {pc[PC_LSB + BTB_BITS +: BTB_TAG_W], pc[PC_LSB +: BTB_BITS]};
        e.chooser_idx = pc[PC_LSB +: CHOOSER_BITS];
        return e;
    endfunction

    task automatic add_row(input op_e op, input logic [PC_W-1:0] pc, input logic taken,
                           input logic [PC_W-1:0] target, input logic exp_taken,
                           input logic [PC_W-1:0] exp_target);
        row_t r;
        r.op         = op;
        r.pc         = pc;
        r.taken      = taken;
        r.target     = target;
        r.exp_taken  = exp_taken;
        r.exp_target = exp_target;
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [PC_W-1:0] pc;
        // untrained tables, any pc gives not taken and no target
        for (int i = 0; i < 8; i++) begin
            pc      = $random(seed);
            pc[1:0] = 2'b00;
            add_row(op_predict, pc, 1'b0, '0, 1'b0, '0);
        end
        // branch 1040 trained taken twice, chooser moves to global on the disagreement
        add_row(op_predict, 32'h0000_1040, 1'b0, '0, 1'b0, '0);
        add_row(op_commit,  32'h0000_1040, 1'b1, '0, 1'b0, '0);
        add_row(op_predict, 32'h0000_1040, 1'b0, '0, 1'b0, '0);
        add_row(op_commit,  32'h0000_1040, 1'b1, '0, 1'b0, '0);
        add_row(op_predict, 32'h0000_1040, 1'b0, '0, 1'b1, '0);
        // indirect branch 2080, then 5080 on the same set with another tag
        add_row(op_predict, 32'h0000_2080, 1'b0, '0, 1'b0, '0);
        add_row(op_commit,  32'h0000_2080, 1'b1, 32'h0000_3000, 1'b0, '0);
        add_row(op_predict, 32'h0000_2080, 1'b0, '0, 1'b0, 32'h0000_3000);
        add_row(op_predict, 32'h0000_5080, 1'b0, '0, 1'b0, '0);
        // outputs keep the 5080 result while 2080 is in flight
        add_row(op_hold,    32'h0000_2080, 1'b0, '0, 1'b0, 32'h0000_3000);
        // history 0f after recover moves 1040 off its trained global counter
        add_row(op_commit,  32'h0000_1040, 1'b1, '0, 1'b0, '0);
        add_row(op_recover, 32'h0000_1040, 1'b0, '0, 1'b0, '0);
        // 5080 fetched during the pause must not enter
        add_row(op_pause,   32'h0000_2080, 1'b0, 32'h0000_5080, 1'b0, 32'h0000_3000);
        add_row(op_predict, 32'h0000_1040, 1'b0, '0, 1'b0, '0);
    endtask

    // called at a negedge two cycles after the pc was issued
    task automatic check_outputs(input logic [PC_W-1:0] pc, input logic exp_taken,
                                 input logic [PC_W-1:0] exp_target);
        check_valid("pred_valid_o", pred_valid_o, 1'b1);
        check_taken("pred_taken_o", pred_taken_o, exp_taken);
        check_target("pred_target_o", pred_target_o, exp_target);
        check_info_index(pred_info_o, expected_info(pc));
        info_by_pc[pc]  = pred_info_o;
        pred_by_pc[pc]  = pred_taken_o;
        last_exp_taken  = exp_taken;
        last_exp_target = exp_target;
    endtask

    task automatic run_predict(input row_t r);
        fetch_valid_i = 1'b1;
        br_pc_i       = r.pc;
        @(negedge clk);
        fetch_valid_i = 1'b0;
        @(negedge clk);
        check_outputs(r.pc, r.exp_taken, r.exp_target);
    endtask

    task automatic run_commit(input row_t r);
        bht_index_t b;
        b = r.pc[PC_LSB +: BHT_BITS];
        if (!info_by_pc.exists(r.pc)) begin
            error_count++;
            $display("commit of pc %h has no earlier prediction in the table", r.pc);
        end else begin
            commit_valid_i     = 1'b1;
            commit_info_i      = info_by_pc[r.pc];
            commit_taken_i     = r.taken;
            commit_mispred_i   = (pred_by_pc[r.pc] != r.taken);
            commit_target_en_i = (r.target != '0);
            commit_target_i    = r.target;
            lhist_model[b]     = {lhist_model[b][LHIST_W-2:0], r.taken};
            commit_hist_model  = {commit_hist_model[GHIST_W-2:0], r.taken};
            @(negedge clk);
            commit_valid_i     = 1'b0;
            commit_target_en_i = 1'b0;
        end
    endtask

    task automatic run_hold(input row_t r);
        logic            held_taken;
        logic [PC_W-1:0] held_target;
        // the earlier prediction stays on the outputs
        held_taken    = last_exp_taken;
        held_target   = last_exp_target;
        hold_i        = 1'b1;
        fetch_valid_i = 1'b1;
        br_pc_i       = r.pc;
        @(negedge clk);
        fetch_valid_i = 1'b0;
        for (int i = 0; i < 3; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            check_valid("pred_valid_o (hold)", pred_valid_o, 1'b1);
            check_taken("pred_taken_o (hold)", pred_taken_o, held_taken);
            check_target("pred_target_o (hold)", pred_target_o, held_target);
        end
        // release and issue the pc again
        hold_i = 1'b0;
        run_predict(r);
    endtask

    task automatic run_recover(input row_t r);
        recover_i = 1'b1;
        @(negedge clk);
        recover_i       = 1'b0;
        spec_hist_model = commit_hist_model;
        run_predict(r);
    endtask

    task automatic run_pause(input row_t r);
        fetch_valid_i = 1'b1;
        br_pc_i       = r.pc;
        @(negedge clk);
        pause_i = 1'b1;
        br_pc_i = r.target;
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_outputs(r.pc, r.exp_taken, r.exp_target);
        end
        pause_i       = 1'b0;
        fetch_valid_i = 1'b0;
        // frozen table stage drains into the output register
        @(negedge clk);
        check_outputs(r.pc, r.exp_taken, r.exp_target);
    endtask

    initial begin
        clk                = 1'b0;
        rst                = 1'b1;
        pause_i            = 1'b0;
        hold_i             = 1'b0;
        recover_i          = 1'b0;
        fetch_valid_i      = 1'b0;
        br_pc_i            = '0;
        if3_is_br_i        = 1'b0;
        if3_is_j_i         = 1'b0;
        commit_valid_i     = 1'b0;
        commit_info_i      = '0;
        commit_taken_i     = 1'b0;
        commit_mispred_i   = 1'b0;
        commit_target_en_i = 1'b0;
        commit_target_i    = '0;
        check_count        = 0;
        error_count        = 0;
        cycle_count        = 0;
        last_exp_taken     = 1'b0;
        last_exp_target    = '0;
        commit_hist_model  = '0;
        spec_hist_model    = '0;
        for (int i = 0; i < BHT_ENTRIES; i++) begin
            lhist_model[i] = '0;
        end
        seed = 32'hf874d89e;
        build_table();
        cycle_limit = rows.size() * 6 + 50;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // no fetch and no stored target yet, so the first output is invalid
        @(negedge clk);
        check_valid("pred_valid_o", pred_valid_o, 1'b0);

        foreach (rows[i]) begin
            case (rows[i].op)
                op_predict: run_predict(rows[i]);
                op_commit:  run_commit(rows[i]);
                op_hold:    run_hold(rows[i]);
                op_recover: run_recover(rows[i]);
                op_pause:   run_pause(rows[i]);
                default:    run_predict(rows[i]);
            endcase
        end

        @(negedge clk);
        $display("checks run: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: hw/bp_commit_if.sv
`timescale 1ns/1ps

// registered commit bundle, one driver and three readers
interface bp_commit_if import bp_pkg::*; ();

    // one-cycle write strobe, no back-pressure
    logic               valid;
    pred_info_t         pred_info;
    // real branch outcome
    logic               taken;
    // chosen direction turned out wrong
    logic               mispred;
    // indirect branch, write the target buffer
    logic               target_en;
    logic [PC_W-1:0]    target;

    // commit register side
    modport ctrl (
        output valid, pred_info, taken, mispred, target_en, target
    );

    // read side used by the three tables
    modport tbl (
        input valid, pred_info, taken, mispred, target_en, target
    );

endinterface

// File: hw/bp_pkg.sv
package bp_pkg;

    // address and table geometry
    localparam int PC_W         = 32;
    // instructions are word aligned, index bits start above the byte offset
    localparam int PC_LSB       = 2;
    localparam int BHT_BITS     = 6;
    localparam int LHIST_W      = 6;
    localparam int GHIST_W      = 8;
    localparam int BTB_BITS     = 6;
    localparam int BTB_TAG_W    = 8;
    localparam int CHOOSER_BITS = 6;

    // pattern tables are indexed by history xor pc, so as wide as the history
    localparam int LPHT_BITS = LHIST_W;
    localparam int GPHT_BITS = GHIST_W;
    localparam int BTB_ID_W  = BTB_TAG_W + BTB_BITS;

    localparam int BHT_ENTRIES     = 1 << BHT_BITS;
    localparam int LPHT_ENTRIES    = 1 << LPHT_BITS;
    localparam int GPHT_ENTRIES    = 1 << GPHT_BITS;
    localparam int BTB_ENTRIES     = 1 << BTB_BITS;
    localparam int CHOOSER_ENTRIES = 1 << CHOOSER_BITS;

    typedef logic [BHT_BITS-1:0]     bht_index_t;
    typedef logic [LPHT_BITS-1:0]    lpht_index_t;
    typedef logic [GPHT_BITS-1:0]    gpht_index_t;
    // tag in the upper bits, set index in the lower bits
    typedef logic [BTB_ID_W-1:0]     btb_index_t;
    typedef logic [CHOOSER_BITS-1:0] chooser_index_t;

    // 2-bit saturating counter, upper half means taken (or global for the chooser)
    typedef enum logic [1:0] {
        strong_not   = 2'b00,
        weak_not     = 2'b01,
        weak_taken   = 2'b10,
        strong_taken = 2'b11
    } counter_e;

    // travels down the pipe with the branch, comes back at commit
    typedef struct packed {
        bht_index_t     bht_idx;
        lpht_index_t    lpht_idx;
        gpht_index_t    gpht_idx;
        btb_index_t     btb_idx;
        chooser_index_t chooser_idx;
        logic           local_taken;
        logic           global_taken;
        logic           use_global;
    } pred_info_t;

    function automatic logic counter_taken(input counter_e c);
        return c inside {weak_taken, strong_taken};
    endfunction

    // saturating step toward the outcome
    function automatic counter_e counter_next(input counter_e c, input logic taken);
        counter_e n;
        case (c)
            strong_not:   n = taken ? weak_not : strong_not;
            weak_not:     n = taken ? weak_taken : strong_not;
            weak_taken:   n = taken ? strong_taken : weak_not;
            strong_taken: n = taken ? strong_taken : weak_taken;
            default:      n = weak_not;
        endcase
        return n;
    endfunction

endpackage

// File: hw/bp_top.sv
`timescale 1ns/1ps

module bp_top import bp_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            pause_i,
    input  logic            hold_i,
    input  logic            recover_i,
    input  logic            fetch_valid_i,
    input  logic [PC_W-1:0] br_pc_i,
    input  logic            if3_is_br_i,
    input  logic            if3_is_j_i,
    input  logic            commit_valid_i,
    input  pred_info_t      commit_info_i,
    input  logic            commit_taken_i,
    input  logic            commit_mispred_i,
    input  logic            commit_target_en_i,
    input  logic [PC_W-1:0] commit_target_i,
    output logic            pred_valid_o,
    output logic            pred_taken_o,
    output logic [PC_W-1:0] pred_target_o,
    output pred_info_t      pred_info_o
);

    bp_commit_if commit_bus ();

    logic [PC_W-1:0] br_pc_q;
    logic            fetch_valid_q;
    logic            local_taken;
    bht_index_t      local_bht_idx;
    lpht_index_t     local_pht_idx;
    logic            global_taken;
    gpht_index_t     global_pht_idx;
    logic            btb_hit;
    logic [PC_W-1:0] btb_target;
    btb_index_t      btb_idx;
    logic            spec_valid;
    logic            spec_taken;

    // speculative history input, jumps always count as taken
    assign spec_valid = if3_is_br_i | if3_is_j_i;
    assign spec_taken = pred_taken_o | if3_is_j_i;

    local_hist_predictor u_local (
        .clk             (clk),
        .rst             (rst),
        .pause_i         (pause_i),
        .fetch_valid_i   (fetch_valid_i),
        .br_pc_i         (br_pc_i),
        .br_pc_q_o       (br_pc_q),
        .fetch_valid_q_o (fetch_valid_q),
        .taken_o         (local_taken),
        .bht_idx_o       (local_bht_idx),
        .pht_idx_o       (local_pht_idx),
        .commit          (commit_bus.tbl)
    );

    global_hist_predictor u_global (
        .clk          (clk),
        .rst          (rst),
        .br_pc_q_i    (br_pc_q),
        .recover_i    (recover_i),
        .spec_valid_i (spec_valid),
        .spec_taken_i (spec_taken),
        .taken_o      (global_taken),
        .pht_idx_o    (global_pht_idx),
        .commit       (commit_bus.tbl)
    );

    branch_target_buffer u_btb (
        .clk       (clk),
        .rst       (rst),
        .br_pc_q_i (br_pc_q),
        .hit_o     (btb_hit),
        .target_o  (btb_target),
        .idx_o     (btb_idx),
        .commit    (commit_bus.tbl)
    );

    branch_predictor_ctrl u_ctrl (
        .clk                (clk),
        .rst                (rst),
        .hold_i             (hold_i),
        .commit_valid_i     (commit_valid_i),
        .commit_info_i      (commit_info_i),
        .commit_taken_i     (commit_taken_i),
        .commit_mispred_i   (commit_mispred_i),
        .commit_target_en_i (commit_target_en_i),
        .commit_target_i    (commit_target_i),
        .br_pc_q_i          (br_pc_q),
        .local_taken_i      (local_taken),
        .local_bht_idx_i    (local_bht_idx),
        .local_pht_idx_i    (local_pht_idx),
        .global_taken_i     (global_taken),
        .global_pht_idx_i   (global_pht_idx),
        .btb_hit_i          (btb_hit),
        .btb_target_i       (btb_target),
        .btb_idx_i          (btb_idx),
        .fetch_valid_q_i    (fetch_valid_q),
        .pred_valid_o       (pred_valid_o),
        .pred_taken_o       (pred_taken_o),
        .pred_target_o      (pred_target_o),
        .pred_info_o        (pred_info_o),
        .commit             (commit_bus.ctrl)
    );

endmodule

// File: hw/branch_predictor_ctrl.sv
`timescale 1ns/1ps

module branch_predictor_ctrl import bp_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            hold_i,
    // raw commit from the core
    input  logic            commit_valid_i,
    input  pred_info_t      commit_info_i,
    input  logic            commit_taken_i,
    input  logic            commit_mispred_i,
    input  logic            commit_target_en_i,
    input  logic [PC_W-1:0] commit_target_i,
    // table results for the registered pc
    input  logic [PC_W-1:0] br_pc_q_i,
    input  logic            local_taken_i,
    input  bht_index_t      local_bht_idx_i,
    input  lpht_index_t     local_pht_idx_i,
    input  logic            global_taken_i,
    input  gpht_index_t     global_pht_idx_i,
    input  logic            btb_hit_i,
    input  logic [PC_W-1:0] btb_target_i,
    input  btb_index_t      btb_idx_i,
    input  logic            fetch_valid_q_i,
    output logic            pred_valid_o,
    output logic            pred_taken_o,
    output logic [PC_W-1:0] pred_target_o,
    output pred_info_t      pred_info_o,
    bp_commit_if.ctrl       commit
);

    // upper half selects the global predictor
    counter_e chooser [CHOOSER_ENTRIES];

    chooser_index_t chooser_idx;
    logic           use_global;
    logic           taken_sel;
    logic           train_chooser;
    logic           global_right;
    pred_info_t     info_d;

    // commit register, tables write one edge later
    always_ff @(posedge clk) begin
        if (rst) begin
            commit.valid <= 1'b0;
        end else begin
            commit.valid <= commit_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        commit.pred_info <= commit_info_i;
        commit.taken     <= commit_taken_i;
        commit.mispred   <= commit_mispred_i;
        commit.target_en <= commit_target_en_i;
        commit.target    <= commit_target_i;
    end

    // selection for the pc in the table stage
    assign chooser_idx = br_pc_q_i[PC_LSB +: CHOOSER_BITS];
    assign use_global  = counter_taken(chooser[chooser_idx]);
    assign taken_sel   = use_global ? global_taken_i : local_taken_i;

    // only a disagreement tells which predictor is better here
    assign train_chooser = commit.valid &&
        (commit.pred_info.local_taken != commit.pred_info.global_taken);
    // chosen side was right unless the branch mispredicted
    assign global_right  = commit.pred_info.use_global ^ commit.mispred;

    always_ff @(posedge clk) begin
        if (rst) begin
            // start out preferring local
            for (int i = 0; i < CHOOSER_ENTRIES; i++) begin
                chooser[i] <= weak_not;
            end
        end else if (train_chooser) begin
            chooser[commit.pred_info.chooser_idx] <=
                counter_next(chooser[commit.pred_info.chooser_idx], global_right);
        end
    end

    // info bundle handed to the pipeline
    always_comb begin
        info_d              = '0;
        info_d.bht_idx      = local_bht_idx_i;
        info_d.lpht_idx     = local_pht_idx_i;
        info_d.gpht_idx     = global_pht_idx_i;
        info_d.btb_idx      = btb_idx_i;
        info_d.chooser_idx  = chooser_idx;
        info_d.local_taken  = local_taken_i;
        info_d.global_taken = global_taken_i;
        info_d.use_global   = use_global;
    end

    // output register, frozen by hold
    always_ff @(posedge clk) begin
        if (rst) begin
            pred_valid_o  <= 1'b0;
            pred_taken_o  <= 1'b0;
            pred_target_o <= '0;
            pred_info_o   <= '0;
        end else if (!hold_i) begin
            pred_valid_o  <= fetch_valid_q_i | btb_hit_i;
            pred_taken_o  <= taken_sel;
            pred_target_o <= btb_target_i;
            pred_info_o   <= info_d;
        end
    end

endmodule

// File: hw/branch_target_buffer.sv
`timescale 1ns/1ps

module branch_target_buffer import bp_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [PC_W-1:0] br_pc_q_i,
    output logic            hit_o,
    output logic [PC_W-1:0] target_o,
    output btb_index_t      idx_o,
    bp_commit_if.tbl        commit
);

    logic                 entry_valid [BTB_ENTRIES];
    logic [BTB_TAG_W-1:0] entry_tag [BTB_ENTRIES];
    logic [PC_W-1:0]      entry_target [BTB_ENTRIES];

    logic [BTB_BITS-1:0]  rd_set;
    logic [BTB_TAG_W-1:0] rd_tag;
    logic [BTB_BITS-1:0]  wr_set;
    logic [BTB_TAG_W-1:0] wr_tag;
    logic                 wr_en;

    // set from low pc bits, tag from the bits just above
    assign rd_set = br_pc_q_i[PC_LSB +: BTB_BITS];
    assign rd_tag = br_pc_q_i[PC_LSB + BTB_BITS +: BTB_TAG_W];
    // tag and set travel together in the info bundle
    assign idx_o  = {rd_tag, rd_set};

    assign hit_o    = entry_valid[rd_set] && (entry_tag[rd_set] == rd_tag);
    // zero target on a miss
    assign target_o = hit_o ? entry_target[rd_set] : '0;

    // indirect commits only
    assign wr_en  = commit.valid && commit.target_en;
    assign wr_set = commit.pred_info.btb_idx[BTB_BITS-1:0];
    assign wr_tag = commit.pred_info.btb_idx[BTB_ID_W-1:BTB_BITS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                entry_valid[i] <= 1'b0;
            end
        end else if (wr_en) begin
            entry_valid[wr_set] <= 1'b1;
        end
    end

    // tag and target storage, qualified by the valid bits
    always_ff @(posedge clk) begin
        if (wr_en) begin
            entry_tag[wr_set]    <= wr_tag;
            entry_target[wr_set] <= commit.target;
        end
    end

endmodule

// File: hw/global_hist_predictor.sv
`timescale 1ns/1ps

module global_hist_predictor import bp_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [PC_W-1:0] br_pc_q_i,
    input  logic            recover_i,
    input  logic            spec_valid_i,
    input  logic            spec_taken_i,
    output logic            taken_o,
    output gpht_index_t     pht_idx_o,
    bp_commit_if.tbl        commit
);

    counter_e gpht [GPHT_ENTRIES];

    // speculative history follows fetch, committed history follows retire
    logic [GHIST_W-1:0] ghist_spec;
    logic [GHIST_W-1:0] ghist_commit;
    logic [GHIST_W-1:0] ghist_commit_nxt;

    // gshare style index from the speculative history
    assign pht_idx_o = ghist_spec ^ br_pc_q_i[PC_LSB +: GPHT_BITS];
    assign taken_o   = counter_taken(gpht[pht_idx_o]);

    // committed history after this edge
    // recover copies this value, so a commit landing on the same edge is kept
    always_comb begin
        ghist_commit_nxt = ghist_commit;
        if (commit.valid) begin
            ghist_commit_nxt = {ghist_commit[GHIST_W-2:0], commit.taken};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ghist_spec   <= '0;
            ghist_commit <= '0;
        end else begin
            ghist_commit <= ghist_commit_nxt;
            // recover wins over a speculative shift in the same cycle
            if (recover_i) begin
                ghist_spec <= ghist_commit_nxt;
            end else if (spec_valid_i) begin
                ghist_spec <= {ghist_spec[GHIST_W-2:0], spec_taken_i};
            end
        end
    end

    // counter training with the index captured at prediction time
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < GPHT_ENTRIES; i++) begin
                gpht[i] <= weak_not;
            end
        end else if (commit.valid) begin
            gpht[commit.pred_info.gpht_idx] <=
                counter_next(gpht[commit.pred_info.gpht_idx], commit.taken);
        end
    end

endmodule

// File: hw/local_hist_predictor.sv
`timescale 1ns/1ps

module local_hist_predictor import bp_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            pause_i,
    input  logic            fetch_valid_i,
    input  logic [PC_W-1:0] br_pc_i,
    output logic [PC_W-1:0] br_pc_q_o,
    output logic            fetch_valid_q_o,
    output logic            taken_o,
    output bht_index_t      bht_idx_o,
    output lpht_index_t     pht_idx_o,
    bp_commit_if.tbl        commit
);

    // per-branch history and the shared local pattern counters
    logic [LHIST_W-1:0] bht [BHT_ENTRIES];
    counter_e           lpht [LPHT_ENTRIES];

    logic [LHIST_W-1:0] lhist;

    // fetch register, shared with the other tables
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_valid_q_o <= 1'b0;
            br_pc_q_o       <= '0;
        end else if (!pause_i) begin
            fetch_valid_q_o <= fetch_valid_i;
            // keep the last branch pc on a bubble
            if (fetch_valid_i) begin
                br_pc_q_o <= br_pc_i;
            end
        end
    end

    // lookup from the registered pc
    assign bht_idx_o = br_pc_q_o[PC_LSB +: BHT_BITS];
    assign lhist     = bht[bht_idx_o];
    // history hashed with low pc bits to spread aliasing
    assign pht_idx_o = lhist ^ br_pc_q_o[PC_LSB +: LPHT_BITS];
    assign taken_o   = counter_taken(lpht[pht_idx_o]);

    // training at commit, indices come back in the info bundle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                bht[i] <= '0;
            end
            for (int i = 0; i < LPHT_ENTRIES; i++) begin
                lpht[i] <= weak_not;
            end
        end else if (commit.valid) begin
            lpht[commit.pred_info.lpht_idx] <=
                counter_next(lpht[commit.pred_info.lpht_idx], commit.taken);
            // newest outcome enters at bit 0
            bht[commit.pred_info.bht_idx] <=
                {bht[commit.pred_info.bht_idx][LHIST_W-2:0], commit.taken};
        end
    end

endmodule

// File: list.f
hw/bp_pkg.sv
hw/bp_commit_if.sv
hw/local_hist_predictor.sv
hw/global_hist_predictor.sv
hw/branch_target_buffer.sv
hw/branch_predictor_ctrl.sv
hw/bp_top.sv
dv/bp_properties.sv
dv/bp_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the branch predictor testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module bp_tb \
    -f list.f \
    -o Vbp_tb

./obj_dir/Vbp_tb 2>&1 | tee sim.log

if grep -q "PASS: all tests" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
